//--- project.f
src/soc_map_pkg.sv
src/soc_timing_pkg.sv
src/reset_ctrl.sv
src/time_keeper.sv
src/pin_io.sv
src/mmio_bridge.sv
src/lora_node_periph.sv
bench/tb_clock_gen.sv
bench/lora_node_asserts.sv
bench/tb_lora_node.sv

//--- Makefile
SIM      = verilator
TOP      = tb_lora_node
FILELIST = project.f
OBJ_DIR  = obj_dir
VFLAGS   = --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LFLAGS   = --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

lint:
	$(SIM) $(LFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_lora_node.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lora_node;

    localparam int         CLK_PER_US = 25;
    localparam int         RESET_HOLD = 32;
    localparam logic [7:0] IDLE_PINS  = 8'b0001_0011;   // TX, radio reset and CS idle high

    logic               clk;
    logic               rst_reg_n;
    soc_map_pkg::addr_t i_addr;
    logic [1:0]         i_write_n;
    logic [1:0]         i_read_n;
    soc_map_pkg::word_t i_wdata;
    logic [7:0]         i_ui;
    soc_map_pkg::word_t o_rdata;
    logic [7:0]         o_uo;
    logic               o_irq_timer;
    logic               o_irq_dio1;

    // Register file model
    logic [7:0]                 m_gpio_out;
    logic [7:0]                 m_gpio_sel;
    logic [7:0]                 m_ui;
    soc_timing_pkg::pps_count_t m_pps;
    soc_timing_pkg::count_t     m_timer;

    tb_clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(8)) u_clock_gen (
        .clk       (clk),
        .rst_reg_n (rst_reg_n)
    );

    lora_node_periph #(
        .CLK_PER_US  (CLK_PER_US),
        .RESET_HOLD  (RESET_HOLD)
    ) UUT (
        .clk         (clk),
        .rst_reg_n   (rst_reg_n),
        .i_addr      (i_addr),
        .i_write_n   (i_write_n),
        .i_read_n    (i_read_n),
        .i_wdata     (i_wdata),
        .i_ui        (i_ui),
        .o_rdata     (o_rdata),
        .o_uo        (o_uo),
        .o_irq_timer (o_irq_timer),
        .o_irq_dio1  (o_irq_dio1)
    );

    // ==================================================
    // Reference model
    // ==================================================
    function automatic soc_map_pkg::addr_t slot_addr(input soc_map_pkg::periph_slot_e slot);
        logic [4:0] code;
        code = slot;
        return {soc_map_pkg::PERIPH_BASE, code[3:0], 2'b00};
    endfunction

    function automatic logic [7:0] pin_formula(input logic [7:0] out, input logic [7:0] sel);
        logic [7:0] pins;
        for (int b = 0; b < 8; b++) begin
            pins[b] = sel[b] ? out[b] : IDLE_PINS[b];   // Per pin mux
        end
        return pins;
    endfunction

    function automatic soc_map_pkg::word_t expected_read(input soc_map_pkg::addr_t addr);
        soc_map_pkg::periph_slot_e slot;
        if (addr[27:6] != soc_map_pkg::PERIPH_BASE || addr[1:0] != 2'b00) begin
            return 32'hffff_ffff;                       // Outside the window
        end
        slot = soc_map_pkg::periph_slot_e'({1'b0, addr[5:2]});
        case (slot)
            soc_map_pkg::GPIO_OUT:     return {24'h0, pin_formula(m_gpio_out, m_gpio_sel)};
            soc_map_pkg::GPIO_IN:      return {24'h0, m_ui};
            soc_map_pkg::GPIO_OUT_SEL: return {24'h0, m_gpio_sel};
            soc_map_pkg::TIMER:        return m_timer;
            soc_map_pkg::SYSINFO:      return {m_pps, 8'h01, 8'h10};  // PPS, chip ID, version
            default:                   return 32'h0;    // Session count not modelled
        endcase
    endfunction

    // ==================================================
    // Checks
    // ==================================================
    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic timed_out(input string what);
        $display("Timed out waiting for %s", what);
        stop_with_failure();
    endtask

    task automatic check_word(input soc_map_pkg::word_t got, input soc_map_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_pins(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Every read is checked mid-cycle
    always @(negedge clk) begin
        if (i_read_n != 2'b11) begin
            check_word(o_rdata, expected_read(i_addr), $sformatf("read of %h", i_addr));
        end
    end

    // ==================================================
    // Bus and reset helpers
    // ==================================================
    task automatic bus_write(input soc_map_pkg::periph_slot_e slot,
                             input soc_map_pkg::word_t data);
        @(posedge clk);
        i_addr    <= slot_addr(slot);
        i_wdata   <= data;
        i_write_n <= 2'b00;
        @(posedge clk);
        i_write_n <= 2'b11;                             // Register took it on this edge
        case (slot)
            soc_map_pkg::GPIO_OUT:     m_gpio_out = data[7:0];
            soc_map_pkg::GPIO_OUT_SEL: m_gpio_sel = data[7:0];
            soc_map_pkg::TIMER:        m_timer = data;
            default: ;
        endcase
    endtask

    task automatic bus_read(input soc_map_pkg::addr_t addr);
        @(posedge clk);
        i_addr   <= addr;
        i_read_n <= 2'b00;
        @(posedge clk);
        i_read_n <= 2'b11;
    endtask

    task automatic wait_core_reset(input logic level, input int limit, input string cause);
        int n = 0;
        @(negedge clk);
        while (UUT.core_rst_n !== level) begin
            if (n >= limit) begin
                timed_out(cause);
            end
            @(negedge clk);
            n++;
        end
    endtask

    // Internal reset clears GPIO, counts and timer
    task automatic await_internal_reset(input int assert_limit, input string cause);
        wait_core_reset(1'b0, assert_limit, {cause, " assert"});
        wait_core_reset(1'b1, RESET_HOLD + 4, {cause, " release"});
        m_gpio_out = 8'h00;
        m_gpio_sel = 8'h00;
        m_pps      = '0;
        m_timer    = '0;
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        int latency;
        void'($urandom(32'h43450716));
        i_addr     = '0;
        i_write_n  = 2'b11;
        i_read_n   = 2'b11;
        i_wdata    = '0;
        i_ui       = 8'h00;
        m_gpio_out = 8'h00;
        m_gpio_sel = 8'h00;
        m_ui       = 8'h00;
        m_pps      = '0;
        m_timer    = '0;
        wait_core_reset(1'b1, 16, "power-on reset release");

        // Random GPIO traffic, DIO1 and PPS bits kept low
        for (int i = 0; i < 8; i++) begin
            bus_write(soc_map_pkg::GPIO_OUT, $urandom());
            bus_write(soc_map_pkg::GPIO_OUT_SEL, $urandom());
            @(negedge clk);
            check_pins(o_uo, pin_formula(m_gpio_out, m_gpio_sel), "o_uo after GPIO writes");
            bus_read(slot_addr(soc_map_pkg::GPIO_OUT));
            bus_read(slot_addr(soc_map_pkg::GPIO_OUT_SEL));
            @(posedge clk);
            m_ui = 8'($urandom()) & 8'hee;
            i_ui <= m_ui;
            bus_read(slot_addr(soc_map_pkg::GPIO_IN));
        end
        @(posedge clk);
        i_ui <= 8'h00;
        m_ui = 8'h00;

        // Unmapped, misaligned and unfitted slots
        bus_read(28'h000_0040);
        bus_read(slot_addr(soc_map_pkg::GPIO_IN) | 28'h1);
        bus_read(slot_addr(soc_map_pkg::UART));
        bus_read(slot_addr(soc_map_pkg::CRC16));
        bus_read(slot_addr(soc_map_pkg::RTC));

        // Timer with N = 3
        bus_write(soc_map_pkg::TIMER, 32'd3);
        latency = 0;
        @(negedge clk);
        while (!o_irq_timer) begin
            if (latency > 3 * CLK_PER_US + 8) begin
                timed_out("timer interrupt");
            end
            @(negedge clk);
            latency++;
        end
        if (latency < 2 * CLK_PER_US + 1 || latency > 3 * CLK_PER_US) begin
            $display("mismatch at %0t: timer interrupt after %0d cycles, expected %0d to %0d",
                     $time, latency, 2 * CLK_PER_US + 1, 3 * CLK_PER_US);
            stop_with_failure();
        end
        m_timer = '0;
        bus_read(slot_addr(soc_map_pkg::TIMER));
        check_bit(o_irq_timer, 1'b1, "sticky timer interrupt");
        bus_write(soc_map_pkg::TIMER, 32'd1000);
        @(negedge clk);
        check_bit(o_irq_timer, 1'b0, "timer interrupt after rewrite");
        bus_write(soc_map_pkg::TIMER, 32'd0);
        bus_read(slot_addr(soc_map_pkg::TIMER));

        // Five PPS pulses, then DIO1
        for (int k = 0; k < 5; k++) begin
            @(posedge clk);
            i_ui <= 8'h10;
            repeat (4) @(posedge clk);
            i_ui <= 8'h00;
            repeat (4) @(posedge clk);                  // Edge counted 3 cycles on
        end
        m_pps = m_pps + 16'd5;
        bus_read(slot_addr(soc_map_pkg::SYSINFO));
        @(posedge clk);
        i_ui <= 8'h01;
        @(posedge clk);
        i_ui <= 8'h00;                                  // One cycle high on DIO1
        @(negedge clk);
        check_bit(o_irq_dio1, 1'b1, "o_irq_dio1 rise");
        @(posedge clk);
        @(negedge clk);
        check_bit(o_irq_dio1, 1'b0, "o_irq_dio1 fall");

        // Soft reset, wrong key first
        bus_write(soc_map_pkg::GPIO_OUT, 32'h0000_00c8);
        bus_write(soc_map_pkg::GPIO_OUT_SEL, 32'h0000_00ff);
        bus_write(soc_map_pkg::SYSINFO, 32'h0000_005a);
        bus_write(soc_map_pkg::SYSINFO, 32'h0000_a500);  // Key in wrong byte
        repeat (RESET_HOLD + 4) begin
            @(negedge clk);
            check_bit(UUT.core_rst_n, 1'b1, "core reset without key");
        end
        check_pins(o_uo, pin_formula(m_gpio_out, m_gpio_sel), "o_uo after keyless write");
        bus_write(soc_map_pkg::SYSINFO, 32'h0000_12a5);
        await_internal_reset(4, "soft reset");
        check_pins(o_uo, IDLE_PINS, "o_uo after soft reset");
        bus_read(slot_addr(soc_map_pkg::GPIO_OUT_SEL));
        bus_read(slot_addr(soc_map_pkg::SYSINFO));

        // Watchdog kicked, then left alone
        bus_write(soc_map_pkg::GPIO_OUT, 32'h0000_005c);
        bus_write(soc_map_pkg::GPIO_OUT_SEL, 32'h0000_00f0);
        for (int i = 0; i < 8; i++) begin
            bus_write(soc_map_pkg::WDT, 32'd3);
            repeat (30) begin
                @(negedge clk);
                check_bit(UUT.core_rst_n, 1'b1, "core reset while kicked");
            end
        end
        check_pins(o_uo, pin_formula(m_gpio_out, m_gpio_sel), "o_uo while kicked");
        await_internal_reset(4 * CLK_PER_US + 8, "watchdog reset");
        check_pins(o_uo, IDLE_PINS, "o_uo after watchdog reset");
        bus_read(slot_addr(soc_map_pkg::GPIO_OUT));

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/lora_node_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lora_node_asserts #(
    parameter int HOLD = soc_timing_pkg::DEF_RESET_HOLD
) (
    input wire clk,
    input wire i_rst_n,
    input wire i_trigger,           // Watchdog or soft reset request
    input wire i_core_rst_n,
    input wire i_timer_wr,
    input wire i_irq_timer,
    input wire i_wdt_expire
);

    int unsigned low_left;          // Cycles the core reset must still be low, plus one

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            low_left <= 0;
        end else if (i_trigger) begin
            low_left <= HOLD + 1;                       // First cycle is the register stage
        end else if (low_left != 0) begin
            low_left <= low_left - 1;
        end
    end

    // ==================================================
    // Properties
    // ==================================================
    hold_low: assert property (@(posedge clk) disable iff (!i_rst_n)
        (low_left != 0 && low_left <= HOLD) |-> !i_core_rst_n)
        else $error("core reset released before the hold count ran out");

    expire_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wdt_expire |=> !i_wdt_expire)
        else $error("watchdog expiry longer than one cycle");

    // Load acks the interrupt
    irq_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_timer_wr |=> !i_irq_timer)
        else $error("timer interrupt still set after a timer write");

endmodule

bind reset_ctrl lora_node_asserts #(.HOLD(RESET_HOLD)) u_reset_asserts (
    .clk          (clk),
    .i_rst_n      (rst_reg_n),
    .i_trigger    (trigger),
    .i_core_rst_n (o_core_rst_n),
    .i_timer_wr   (1'b0),
    .i_irq_timer  (1'b0),
    .i_wdt_expire (1'b0)
);

bind time_keeper lora_node_asserts u_timing_asserts (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_trigger    (1'b0),
    .i_core_rst_n (1'b1),
    .i_timer_wr   (i_timer_wr),
    .i_irq_timer  (o_irq_timer),
    .i_wdt_expire (o_wdt_expire)
);

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,             // 10 ns clock
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_reg_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Sync reset, let go on a rising edge
    initial begin
        rst_reg_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_reg_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- src/lora_node_periph.sv
`timescale 1ns/1ps
`default_nettype none

module lora_node_periph #(
    parameter int CLK_PER_US = soc_timing_pkg::DEF_CLK_PER_US,
    parameter int RESET_HOLD = soc_timing_pkg::DEF_RESET_HOLD
) (
    input  wire                     clk,
    input  wire                     rst_reg_n,
    input  wire soc_map_pkg::addr_t i_addr,
    input  wire [1:0]               i_write_n,
    input  wire [1:0]               i_read_n,
    input  wire soc_map_pkg::word_t i_wdata,
    input  wire [7:0]               i_ui,       // [0] DIO1, [4] 1PPS
    output soc_map_pkg::word_t      o_rdata,
    output logic [7:0]              o_uo,
    output logic                    o_irq_timer,
    output logic                    o_irq_dio1
);

    // ==================================================
    // Internal nets
    // ==================================================
    logic                       core_rst_n;
    logic                       wdt_expire;
    logic                       soft_reset;
    logic                       gpio_out_wr;
    logic                       gpio_sel_wr;
    logic                       timer_wr;
    logic                       wdt_kick;
    soc_timing_pkg::count_t     timer_count;
    soc_timing_pkg::count_t     wdt_remaining;
    soc_timing_pkg::pps_count_t pps_count;
    soc_timing_pkg::session_t   session;
    logic [7:0]                 gpio_sel;

    reset_ctrl #(
        .RESET_HOLD     (RESET_HOLD)
    ) u_reset_ctrl (
        .clk            (clk),
        .rst_reg_n      (rst_reg_n),
        .i_wdt_expire   (wdt_expire),
        .i_soft_reset   (soft_reset),
        .o_core_rst_n   (core_rst_n)
    );

    time_keeper #(
        .CLK_PER_US     (CLK_PER_US)
    ) u_time_keeper (
        .clk            (clk),
        .i_rst_n        (core_rst_n),
        .i_pps          (i_ui[4]),
        .i_timer_wr     (timer_wr),
        .i_wdt_kick     (wdt_kick),
        .i_wdata        (i_wdata),
        .o_timer_count  (timer_count),
        .o_irq_timer    (o_irq_timer),
        .o_wdt_remaining(wdt_remaining),
        .o_wdt_expire   (wdt_expire),
        .o_pps_count    (pps_count),
        .o_session      (session)
    );

    // Pins go out and back into GPIO_OUT reads
    pin_io u_pin_io (
        .clk            (clk),
        .i_rst_n        (core_rst_n),
        .i_gpio_out_wr  (gpio_out_wr),
        .i_gpio_sel_wr  (gpio_sel_wr),
        .i_wdata        (i_wdata),
        .i_dio1         (i_ui[0]),
        .o_pins         (o_uo),
        .o_gpio_sel     (gpio_sel),
        .o_irq_dio1     (o_irq_dio1)
    );

    mmio_bridge u_mmio_bridge (
        .i_addr         (i_addr),
        .i_write_n      (i_write_n),
        .i_read_n       (i_read_n),
        .i_wdata        (i_wdata),
        .i_ui           (i_ui),
        .i_pins         (o_uo),
        .i_gpio_sel     (gpio_sel),
        .i_timer_count  (timer_count),
        .i_wdt_remaining(wdt_remaining),
        .i_pps_count    (pps_count),
        .i_session      (session),
        .o_rdata        (o_rdata),
        .o_gpio_out_wr  (gpio_out_wr),
        .o_gpio_sel_wr  (gpio_sel_wr),
        .o_timer_wr     (timer_wr),
        .o_wdt_kick     (wdt_kick),
        .o_soft_reset   (soft_reset)
    );

endmodule

`default_nettype wire

//--- src/mmio_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_bridge (
    input  wire soc_map_pkg::addr_t            i_addr,
    input  wire [1:0]                          i_write_n,
    input  wire [1:0]                          i_read_n,
    input  wire soc_map_pkg::word_t            i_wdata,
    input  wire [7:0]                          i_ui,
    input  wire [7:0]                          i_pins,
    input  wire [7:0]                          i_gpio_sel,
    input  wire soc_timing_pkg::count_t        i_timer_count,
    input  wire soc_timing_pkg::count_t        i_wdt_remaining,
    input  wire soc_timing_pkg::pps_count_t    i_pps_count,
    input  wire soc_timing_pkg::session_t      i_session,
    output soc_map_pkg::word_t                 o_rdata,
    output logic                               o_gpio_out_wr,
    output logic                               o_gpio_sel_wr,
    output logic                               o_timer_wr,
    output logic                               o_wdt_kick,
    output logic                               o_soft_reset
);

    soc_map_pkg::periph_slot_e slot;
    logic                      in_window;
    logic                      wr;

    // ==================================================
    // Address decode
    // ==================================================
    assign in_window = (i_addr[27:6] == soc_map_pkg::PERIPH_BASE) && (i_addr[1:0] == 2'b00);

    always_comb begin
        if (in_window) begin
            slot = soc_map_pkg::periph_slot_e'({1'b0, i_addr[5:2]});
        end else begin
            slot = soc_map_pkg::SLOT_NONE;
        end
    end

    // Any byte lane low is a write
    assign wr = (i_write_n != 2'b11);

    // One cycle strobes, side blocks trust them as is
    assign o_gpio_out_wr = wr && (slot == soc_map_pkg::GPIO_OUT);
    assign o_gpio_sel_wr = wr && (slot == soc_map_pkg::GPIO_OUT_SEL);
    assign o_timer_wr    = wr && (slot == soc_map_pkg::TIMER);
    assign o_wdt_kick    = wr && (slot == soc_map_pkg::WDT);
    assign o_soft_reset  = wr && (slot == soc_map_pkg::SYSINFO)
                           && (i_wdata[7:0] == soc_map_pkg::SOFT_RESET_KEY);

    // ==================================================
    // Read data mux
    // ==================================================
    always_comb begin
        case (slot)
            soc_map_pkg::GPIO_OUT:     o_rdata = {24'h0, i_pins};       // Pins, not the reg
            soc_map_pkg::GPIO_IN:      o_rdata = {24'h0, i_ui};
            soc_map_pkg::GPIO_OUT_SEL: o_rdata = {24'h0, i_gpio_sel};
            soc_map_pkg::TIMER:        o_rdata = i_timer_count;
            soc_map_pkg::WDT:          o_rdata = i_wdt_remaining;
            soc_map_pkg::SEAL_CTRL:    o_rdata = {24'h0, i_session};
            soc_map_pkg::SYSINFO: begin
                o_rdata = {i_pps_count, soc_map_pkg::CHIP_ID, soc_map_pkg::VERSION};
            end
            soc_map_pkg::SLOT_NONE:    o_rdata = soc_map_pkg::RD_UNMAPPED;
            default:                   o_rdata = '0;                   // Unfitted slots
        endcase
    end

endmodule

`default_nettype wire

//--- src/pin_io.sv
`timescale 1ns/1ps
`default_nettype none

module pin_io (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_gpio_out_wr,
    input  wire                     i_gpio_sel_wr,
    input  wire soc_map_pkg::word_t i_wdata,
    input  wire                     i_dio1,         // Radio DIO1
    output logic [7:0]              o_pins,
    output logic [7:0]              o_gpio_sel,
    output logic                    o_irq_dio1
);

    logic [7:0] gpio_out;

    // ==================================================
    // GPIO registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            gpio_out   <= '0;
            o_gpio_sel <= '0;                           // All pins on idle level
        end else begin
            if (i_gpio_out_wr) begin
                gpio_out <= i_wdata[7:0];
            end
            if (i_gpio_sel_wr) begin
                o_gpio_sel <= i_wdata[7:0];
            end
        end
    end

    // ==================================================
    // Output pin select
    // ==================================================

    // Select bit set gives the GPIO bit, clear gives the idle level
    assign o_pins = (o_gpio_sel & gpio_out) | (~o_gpio_sel & soc_map_pkg::PIN_IDLE);

    // DIO1 straight onto the IRQ line, one cycle late
    always_ff @(posedge clk) begin
        o_irq_dio1 <= i_dio1;
    end

endmodule

`default_nettype wire

//--- src/time_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module time_keeper #(
    parameter int CLK_PER_US = soc_timing_pkg::DEF_CLK_PER_US
) (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_pps,           // Raw 1PPS pin
    input  wire                        i_timer_wr,
    input  wire                        i_wdt_kick,
    input  wire soc_map_pkg::word_t    i_wdata,
    output soc_timing_pkg::count_t     o_timer_count,
    output logic                       o_irq_timer,     // Sticky until rewritten
    output soc_timing_pkg::count_t     o_wdt_remaining,
    output logic                       o_wdt_expire,    // One cycle pulse
    output soc_timing_pkg::pps_count_t o_pps_count,
    output soc_timing_pkg::session_t   o_session
);

    localparam int DIV_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
    localparam int MS_W  = $clog2(soc_timing_pkg::US_PER_MS);

    logic [DIV_W-1:0] us_div;
    logic             tick_us;
    logic             wdt_armed;
    logic [1:0]       pps_sync;
    logic             pps_prev;
    logic             pps_rising;
    logic [MS_W-1:0]  ms_div;

    // ==================================================
    // Microsecond tick
    // ==================================================
    assign tick_us = (us_div == DIV_W'(CLK_PER_US - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n || tick_us) begin
            us_div <= '0;
        end else begin
            us_div <= us_div + 1'b1;
        end
    end

    // ==================================================
    // Countdown timer
    // ==================================================
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_timer_count <= '0;
            o_irq_timer   <= 1'b0;
        end else if (i_timer_wr) begin
            o_timer_count <= i_wdata;                   // Load also acks the IRQ
            o_irq_timer   <= 1'b0;
        end else if (tick_us && o_timer_count != '0) begin
            o_timer_count <= o_timer_count - 1'b1;
            if (o_timer_count == 32'd1) begin
                o_irq_timer <= 1'b1;                    // Set on 1 -> 0 only
            end
        end
    end

    // ==================================================
    // Watchdog
    // ==================================================
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wdt_remaining <= '0;
            wdt_armed       <= 1'b0;
            o_wdt_expire    <= 1'b0;
        end else begin
            o_wdt_expire <= 1'b0;
            if (i_wdt_kick) begin
                o_wdt_remaining <= i_wdata;
                wdt_armed       <= 1'b1;
            end else if (wdt_armed) begin
                if (o_wdt_remaining == '0) begin
                    wdt_armed    <= 1'b0;               // Fires once then idles
                    o_wdt_expire <= 1'b1;
                end else if (tick_us) begin
                    o_wdt_remaining <= o_wdt_remaining - 1'b1;
                end
            end
        end
    end

    // ==================================================
    // 1PPS sync, edge detect and count
    // ==================================================
    always_ff @(posedge clk) begin
        pps_sync <= {pps_sync[0], i_pps};               // Two flop synchronizer
        pps_prev <= pps_sync[1];
    end

    assign pps_rising = pps_sync[1] && !pps_prev;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_pps_count <= '0;
        end else if (pps_rising) begin
            o_pps_count <= o_pps_count + 1'b1;
        end
    end

    // Session counter, one step per millisecond
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ms_div    <= '0;
            o_session <= '0;
        end else if (tick_us) begin
            if (ms_div == MS_W'(soc_timing_pkg::US_PER_MS - 1)) begin
                ms_div    <= '0;
                o_session <= o_session + 1'b1;          // Wraps at 256 ms
            end else begin
                ms_div <= ms_div + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/reset_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl #(
    parameter int RESET_HOLD = soc_timing_pkg::DEF_RESET_HOLD
) (
    input  wire  clk,
    input  wire  rst_reg_n,             // External reset, sync, active low
    input  wire  i_wdt_expire,          // Watchdog ran out
    input  wire  i_soft_reset,          // Keyed write to SYSINFO
    output logic o_core_rst_n           // Reset for the rest of the block
);

    localparam int HOLD_W = $clog2(RESET_HOLD + 1);

    logic [HOLD_W-1:0] hold_count;
    logic              trigger;
    logic              combined_rst_n;

    assign trigger = i_wdt_expire | i_soft_reset;

    // ==================================================
    // Hold counter
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            hold_count <= '0;
        end else if (trigger) begin
            hold_count <= HOLD_W'(RESET_HOLD);          // Retrigger restarts the hold
        end else if (hold_count != '0) begin
            hold_count <= hold_count - 1'b1;
        end
    end

    // Released only with external reset gone and hold expired
    assign combined_rst_n = rst_reg_n && (hold_count == '0);

    // One register stage before it fans out
    always_ff @(posedge clk) begin
        o_core_rst_n <= combined_rst_n;
    end

endmodule

`default_nettype wire

//--- src/soc_timing_pkg.sv
`default_nettype none

package soc_timing_pkg;

    // ==================================================
    // Counter types
    // ==================================================
    typedef logic [31:0] count_t;       // Timer and watchdog, microseconds
    typedef logic [15:0] pps_count_t;   // 1PPS edges since reset
    typedef logic [7:0]  session_t;     // Milliseconds, wraps

    // ==================================================
    // Default timing
    // ==================================================

    // 25 MHz system clock
    localparam int DEF_CLK_PER_US = 25;

    // Cycles the internal reset is held after a trigger
    localparam int DEF_RESET_HOLD = 32;

    // Session counter step
    localparam int US_PER_MS = 1000;

endpackage

`default_nettype wire

//--- src/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    // ==================================================
    // Bus types
    // ==================================================
    typedef logic [31:0] word_t;        // Data bus word
    typedef logic [27:0] addr_t;        // Byte address as the core drives it

    // ==================================================
    // Peripheral slots, slot number from addr[5:2]
    // ==================================================
    typedef enum logic [4:0] {
        GPIO_OUT     = 5'h00,           // R/W output register, reads pins
        GPIO_IN      = 5'h01,           // R raw input byte
        CRC16        = 5'h02,           // Not fitted
        GPIO_OUT_SEL = 5'h03,           // R/W per-pin function select
        UART         = 5'h04,           // Not fitted
        UART_STATUS  = 5'h05,           // Not fitted
        I2C_DATA     = 5'h06,           // Not fitted
        I2C_CONFIG   = 5'h07,           // Not fitted
        SPI          = 5'h08,           // Not fitted
        SPI_STATUS   = 5'h09,           // Not fitted
        RTC          = 5'h0a,           // Not fitted
        SEAL_DATA    = 5'h0b,           // Not fitted
        TIMER        = 5'h0c,           // R/W countdown in microseconds
        WDT          = 5'h0d,           // W kick, R remaining
        SEAL_CTRL    = 5'h0e,           // R session millisecond count
        SYSINFO      = 5'h0f,           // R identity, W soft reset key
        SLOT_NONE    = 5'h1f            // Address outside the window
    } periph_slot_e;

    // addr[27:6] of the window, addr[1:0] must be 00 as well
    localparam logic [21:0] PERIPH_BASE = 22'h20_0000;

    // ==================================================
    // Identity and fixed values
    // ==================================================
    localparam logic [7:0] CHIP_ID        = 8'h01;
    localparam logic [7:0] VERSION        = 8'h10;  // Major in high nibble
    localparam logic [7:0] SOFT_RESET_KEY = 8'ha5;  // Low byte to SYSINFO

    // Pin levels when the select bit is clear
    // LED low, I2C released, SCK 0, CS 1, MOSI 0, radio reset high, TX high
    localparam logic [7:0] PIN_IDLE = 8'b0001_0011;

    localparam word_t RD_UNMAPPED = 32'hffff_ffff;

endpackage

`default_nettype wire
